// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module collect_tb -f collect_top.f \
		--Mdir obj_dir -o collect_tb
	@out="$$(./obj_dir/collect_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== collect_top.f ====
+incdir+sim
src/collect_pkg.sv
src/rate_divider.sv
src/lo_nco.sv
src/iq_mixer.sv
src/sample_fifo.sv
src/reg_bank.sv
src/collect_top.sv
sim/collect_tb.sv

// ==== sim/collect_tb_tasks.svh ====
`ifndef COLLECT_TB_TASKS_SVH
`define COLLECT_TB_TASKS_SVH

// both bus tasks are entered on a falling edge and return on a falling edge
task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    wr_en_i = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    @(negedge aclk);
    wr_en_i = 1'b0;
endtask

task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    rd_en_i = 1'b1;
    addr_i  = addr;
    @(negedge aclk);
    rd_en_i = 1'b0;
    data    = rdata_o; // registered on the edge in between
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// oscillator value as +1, 0 or -1 taken from the top two phase bits
function automatic int cos_code(input logic [1:0] quad);
    case (quad)
        2'b00:   return 1;
        2'b10:   return -1;
        default: return 0;
    endcase
endfunction

function automatic int sin_code(input logic [1:0] quad);
    case (quad)
        2'b01:   return 1;
        2'b11:   return -1;
        default: return 0;
    endcase
endfunction

function automatic logic [SAMPLE_W-1:0] mix_one(input logic [SAMPLE_W-1:0] din, input int code);
    if (code == 0) begin
        return '0;
    end
    if (code == 1) begin
        return din;
    end
    if (din == 24'h80_0000) begin
        return 24'h7F_FFFF; // most negative input has no positive twin
    end
    return -din;
endfunction

`endif

// ==== sim/collect_tb.sv ====
`timescale 1ns/1ps

module collect_tb;

    import collect_pkg::*;

    localparam int DIV        = 3;
    localparam int DEPTH_LOG2 = 4;
    localparam int DEPTH      = 2 ** DEPTH_LOG2;
    localparam int NROWS      = 3;

    // one row per capture run, covering every quadrant between them
    localparam logic [31:0] ROW_FREQ [NROWS] = '{32'h0000_0000, 32'h4000_0000, 32'hC000_0000};
    localparam int ROW_THRESH  [NROWS] = '{4, 8, 16};
    localparam int ROW_IRQ_EN  [NROWS] = '{1, 0, 1};
    localparam int ROW_STROBES [NROWS] = '{6, 10, 20};
    localparam int ROW_FILL    [NROWS] = '{6, 10, 16};

    logic                aclk;
    logic                reset_i;
    logic [SAMPLE_W-1:0] din_i = '0;
    logic                wr_en_i;
    logic                rd_en_i;
    logic [ADDR_W-1:0]   addr_i;
    logic [DATA_W-1:0]   wdata_i;
    logic [DATA_W-1:0]   rdata_o;
    logic                irq_i_o;
    logic                irq_q_o;

    logic [31:0]         lcg_state = 32'd20;
    logic                force_min = 1'b0;
    int                  errors = 0;

    // reference model state, updated on every rising edge
    int                  cycle_no;
    int                  run_edge;
    int                  strobe_cnt;
    logic                m_run;
    logic                m_irq_en;
    logic [31:0]         m_freq;
    logic [31:0]         m_phase;
    logic [COUNT_W-1:0]  m_thresh;
    logic                push_pend;
    logic                clear_pend;
    logic [SAMPLE_W-1:0] pend_i;
    logic [SAMPLE_W-1:0] pend_q;
    logic [SAMPLE_W-1:0] model_i [$];
    logic [SAMPLE_W-1:0] model_q [$];

    `include "collect_tb_tasks.svh"

    collect_top #(
        .DIV        (DIV),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) collect_top_inst (
        .aclk    (aclk),
        .reset_i (reset_i),
        .din_i   (din_i),
        .wr_en_i (wr_en_i),
        .rd_en_i (rd_en_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .irq_i_o (irq_i_o),
        .irq_q_o (irq_q_o)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(negedge aclk) begin
        lcg_state = lcg_next(lcg_state);
        din_i = force_min ? 24'h80_0000 : lcg_state[31:8];
    end

    always @(posedge aclk) begin
        logic full_i_now;
        logic full_q_now;
        if (reset_i) begin
            cycle_no = 0;
            run_edge = 0;
            strobe_cnt = 0;
            m_run = 1'b0;
            m_irq_en = 1'b0;
            m_freq = '0;
            m_phase = '0;
            m_thresh = '0;
            push_pend = 1'b0;
            clear_pend = 1'b0;
            model_i.delete();
            model_q.delete();
        end else begin
            cycle_no = cycle_no + 1;
            full_i_now = (model_i.size() == DEPTH);
            full_q_now = (model_q.size() == DEPTH);
            if (clear_pend) begin // flush wins over a push or pop on the same edge
                model_i.delete();
                model_q.delete();
            end else begin
                if (rd_en_i && !wr_en_i && addr_i == REG_FIFO_I && model_i.size() > 0) begin
                    void'(model_i.pop_front());
                end
                if (rd_en_i && !wr_en_i && addr_i == REG_FIFO_Q && model_q.size() > 0) begin
                    void'(model_q.pop_front());
                end
                if (push_pend) begin
                    if (!full_i_now) model_i.push_back(pend_i); // a full FIFO drops it
                    if (!full_q_now) model_q.push_back(pend_q);
                end
            end
            clear_pend = 1'b0;
            push_pend  = 1'b0;
            // strobes fall every DIV edges after the edge that started the run
            if (m_run && ((cycle_no - run_edge) % DIV == 0)) begin
                pend_i = mix_one(din_i, cos_code(m_phase[31:30]));
                pend_q = mix_one(din_i, sin_code(m_phase[31:30]));
                push_pend = 1'b1;
                m_phase = m_phase + m_freq;
                strobe_cnt = strobe_cnt + 1;
            end
            if (wr_en_i) begin
                case (addr_i)
                    REG_FREQ:   m_freq = wdata_i;
                    REG_THRESH: m_thresh = wdata_i[COUNT_W-1:0];
                    REG_CTRL: begin
                        if (m_run && !wdata_i[0]) clear_pend = 1'b1;
                        if (!m_run && wdata_i[0]) begin
                            run_edge = cycle_no;
                            strobe_cnt = 0;
                        end
                        m_run    = wdata_i[0];
                        m_irq_en = wdata_i[1];
                    end
                    default: ;
                endcase
            end
            if (!m_run) m_phase = '0;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors = errors + 1;
        $display("ERR t=%0t %s expected 0x%h got 0x%h", $time, name, expected, actual);
    endtask

    task automatic wait_strobes(input int n);
        while (strobe_cnt < n) begin
            @(negedge aclk);
        end
    endtask

    task automatic check_status(input int count, input logic full, input logic ovf);
        status_word_u st;
        logic [DATA_W-1:0] word;
        bus_read(REG_STATUS, word);
        st.raw = word;
        if (st.fields.count_i !== COUNT_W'(count))
            report_mismatch("status.count_i", 32'(count), 32'(st.fields.count_i));
        if (st.fields.count_q !== COUNT_W'(count))
            report_mismatch("status.count_q", 32'(count), 32'(st.fields.count_q));
        if (st.fields.empty_i !== (count == 0))
            report_mismatch("status.empty_i", 32'(count == 0), 32'(st.fields.empty_i));
        if (st.fields.empty_q !== (count == 0))
            report_mismatch("status.empty_q", 32'(count == 0), 32'(st.fields.empty_q));
        if (st.fields.full_i !== full)
            report_mismatch("status.full_i", 32'(full), 32'(st.fields.full_i));
        if (st.fields.full_q !== full)
            report_mismatch("status.full_q", 32'(full), 32'(st.fields.full_q));
        if (st.fields.overflow_i !== ovf)
            report_mismatch("status.overflow_i", 32'(ovf), 32'(st.fields.overflow_i));
        if (st.fields.overflow_q !== ovf)
            report_mismatch("status.overflow_q", 32'(ovf), 32'(st.fields.overflow_q));
    endtask

    task automatic check_irq();
        logic want_i;
        logic want_q;
        want_i = m_irq_en && (m_thresh != 0) && (model_i.size() >= int'(m_thresh));
        want_q = m_irq_en && (m_thresh != 0) && (model_q.size() >= int'(m_thresh));
        if (irq_i_o !== want_i) report_mismatch("irq_i_o", 32'(want_i), 32'(irq_i_o));
        if (irq_q_o !== want_q) report_mismatch("irq_q_o", 32'(want_q), 32'(irq_q_o));
    endtask

    // the expected head is taken before the edge that pops it
    task automatic pop_and_check(input logic use_q);
        logic [SAMPLE_W-1:0] head;
        logic [DATA_W-1:0]   want;
        logic [DATA_W-1:0]   got;
        head = '0;
        if (use_q && model_q.size() > 0) head = model_q[0];
        if (!use_q && model_i.size() > 0) head = model_i[0];
        want = {{(DATA_W-SAMPLE_W){head[SAMPLE_W-1]}}, head};
        bus_read(use_q ? REG_FIFO_Q : REG_FIFO_I, got);
        if (got !== want)
            report_mismatch(use_q ? "rdata_o(FIFO_Q)" : "rdata_o(FIFO_I)", want, got);
    endtask

    function automatic longint watchdog_ns();
        longint cycles;
        cycles = 0;
        for (int r = 0; r < NROWS; r++) begin
            cycles = cycles + ROW_STROBES[r] * DIV + 200;
        end
        return cycles * 8;
    endfunction

    initial begin
        #(watchdog_ns());
        $display("watchdog expired after %0d ns, the test did not complete", watchdog_ns());
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] rd;
        reset_i = 1'b1;
        wr_en_i = 1'b0;
        rd_en_i = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        reset_i = 1'b0;

        check_status(0, 1'b0, 1'b0);
        check_irq();
        bus_write(REG_FREQ, 32'h1234_5678);
        bus_write(REG_THRESH, 32'h0000_0155);
        bus_write(REG_CTRL, 32'h0000_0002); // irq enable while stopped
        bus_read(REG_FREQ, rd);
        if (rd !== 32'h1234_5678) report_mismatch("rdata_o(REG_FREQ)", 32'h1234_5678, rd);
        bus_read(REG_THRESH, rd);
        if (rd !== 32'h0000_0155) report_mismatch("rdata_o(REG_THRESH)", 32'h0000_0155, rd);
        bus_read(REG_CTRL, rd);
        if (rd !== 32'h0000_0002) report_mismatch("rdata_o(REG_CTRL)", 32'h0000_0002, rd);

        pop_and_check(1'b0);
        pop_and_check(1'b1);
        check_status(0, 1'b0, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            bus_write(REG_FREQ, ROW_FREQ[r]);
            bus_write(REG_THRESH, 32'(ROW_THRESH[r]));
            bus_write(REG_CTRL, (ROW_IRQ_EN[r] != 0) ? 32'd3 : 32'd1);
            wait_strobes(2);
            force_min <= 1'b1; // held for DIV cycles so that the third strobe takes it
            repeat (DIV) @(negedge aclk);
            force_min <= 1'b0;
            wait_strobes(ROW_STROBES[r]);
            @(negedge aclk);
            check_status(ROW_FILL[r], ROW_FILL[r] == DEPTH, ROW_STROBES[r] > DEPTH);
            check_irq();
            for (int k = 0; k < ROW_FILL[r]; k++) begin
                pop_and_check(1'b0);
                pop_and_check(1'b1);
                check_irq();
            end
            bus_write(REG_CTRL, 32'd0);
            @(negedge aclk); // flush lands one edge after the stop
            check_status(0, 1'b0, 1'b0);
            check_irq();
        end

        $display("rows run: %0d  errors: %0d", NROWS, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src/collect_pkg.sv ====
package collect_pkg;

    localparam int SAMPLE_W = 24;
    localparam int PHASE_W  = 32;
    localparam int ADDR_W   = 4;
    localparam int DATA_W   = 32;
    localparam int COUNT_W  = 11; // holds 0..1024 for the deepest FIFO

    localparam logic [ADDR_W-1:0] REG_FREQ   = 'd0;
    localparam logic [ADDR_W-1:0] REG_THRESH = 'd1;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 'd2; // bit 0 run, bit 1 irq enable
    localparam logic [ADDR_W-1:0] REG_STATUS = 'd3;
    localparam logic [ADDR_W-1:0] REG_FIFO_I = 'd4; // read pops one I sample
    localparam logic [ADDR_W-1:0] REG_FIFO_Q = 'd5; // read pops one Q sample

    typedef struct packed {
        logic [3:0]         reserved;
        logic               overflow_q;
        logic               overflow_i;
        logic               full_q;
        logic               full_i;
        logic               empty_q;
        logic               empty_i;
        logic [COUNT_W-1:0] count_q;
        logic [COUNT_W-1:0] count_i;
    } status_fields_t;

    // the status register seen either as one bus word or as its fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        status_fields_t    fields;
    } status_word_u;

endpackage

// ==== src/collect_top.sv ====
`timescale 1ns/1ps

module collect_top #(
    parameter int DIV        = 4,
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                                aclk,
    input  logic                                reset_i,
    input  logic signed [collect_pkg::SAMPLE_W-1:0] din_i,
    input  logic                                wr_en_i,
    input  logic                                rd_en_i,
    input  logic [collect_pkg::ADDR_W-1:0]      addr_i,
    input  logic [collect_pkg::DATA_W-1:0]      wdata_i,
    output logic [collect_pkg::DATA_W-1:0]      rdata_o,
    output logic                                irq_i_o,
    output logic                                irq_q_o
);

    import collect_pkg::*;

    logic                       sample_stb;
    logic [1:0]                 quad;
    logic signed [SAMPLE_W-1:0] mix_i;
    logic signed [SAMPLE_W-1:0] mix_q;
    logic                       mix_valid;
    logic [PHASE_W-1:0]         freq;
    logic [COUNT_W-1:0]         thresh;
    logic                       run;
    logic                       irq_en;
    logic                       clear;
    logic                       pop_i;
    logic                       pop_q;
    logic [SAMPLE_W-1:0]        fifo_i_data;
    logic [SAMPLE_W-1:0]        fifo_q_data;
    logic [COUNT_W-1:0]         count_i;
    logic [COUNT_W-1:0]         count_q;
    logic                       empty_i;
    logic                       empty_q;
    logic                       full_i;
    logic                       full_q;
    logic                       ovf_i;
    logic                       ovf_q;

    rate_divider #(.DIV(DIV)) rate_divider_inst (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .run_i        (run),
        .sample_stb_o (sample_stb)
    );

    lo_nco lo_nco_inst (
        .aclk    (aclk),
        .reset_i (reset_i),
        .step_i  (sample_stb),
        .freq_i  (freq),
        .run_i   (run),
        .quad_o  (quad)
    );

    iq_mixer iq_mixer_inst (
        .aclk    (aclk),
        .reset_i (reset_i),
        .stb_i   (sample_stb),
        .din_i   (din_i),
        .quad_i  (quad),
        .i_o     (mix_i),
        .q_o     (mix_q),
        .valid_o (mix_valid)
    );

    // both FIFOs take every mixer output on the same push
    sample_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) fifo_i_inst (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .push_i     (mix_valid),
        .pop_i      (pop_i),
        .clear_i    (clear),
        .wdata_i    (mix_i),
        .thresh_i   (thresh),
        .irq_en_i   (irq_en),
        .rdata_o    (fifo_i_data),
        .count_o    (count_i),
        .empty_o    (empty_i),
        .full_o     (full_i),
        .overflow_o (ovf_i),
        .irq_o      (irq_i_o)
    );

    sample_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) fifo_q_inst (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .push_i     (mix_valid),
        .pop_i      (pop_q),
        .clear_i    (clear),
        .wdata_i    (mix_q),
        .thresh_i   (thresh),
        .irq_en_i   (irq_en),
        .rdata_o    (fifo_q_data),
        .count_o    (count_q),
        .empty_o    (empty_q),
        .full_o     (full_q),
        .overflow_o (ovf_q),
        .irq_o      (irq_q_o)
    );

    reg_bank reg_bank_inst (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .wr_en_i       (wr_en_i),
        .rd_en_i       (rd_en_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .rdata_o       (rdata_o),
        .freq_o        (freq),
        .thresh_o      (thresh),
        .run_o         (run),
        .irq_en_o      (irq_en),
        .clear_o       (clear),
        .pop_i_o       (pop_i),
        .pop_q_o       (pop_q),
        .fifo_i_data_i (fifo_i_data),
        .fifo_q_data_i (fifo_q_data),
        .count_i_i     (count_i),
        .count_q_i     (count_q),
        .empty_i_i     (empty_i),
        .empty_q_i     (empty_q),
        .full_i_i      (full_i),
        .full_q_i      (full_q),
        .ovf_i_i       (ovf_i),
        .ovf_q_i       (ovf_q)
    );

endmodule

// ==== src/iq_mixer.sv ====
`timescale 1ns/1ps

module iq_mixer (
    input  logic                                aclk,
    input  logic                                reset_i,
    input  logic                                stb_i,
    input  logic signed [collect_pkg::SAMPLE_W-1:0] din_i,
    input  logic [1:0]                          quad_i,
    output logic signed [collect_pkg::SAMPLE_W-1:0] i_o,
    output logic signed [collect_pkg::SAMPLE_W-1:0] q_o,
    output logic                                valid_o
);

    import collect_pkg::*;

    localparam logic signed [SAMPLE_W-1:0] MAX_POS = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] MIN_NEG = {1'b1, {(SAMPLE_W-1){1'b0}}};

    logic signed [SAMPLE_W-1:0] din_neg;
    logic signed [SAMPLE_W-1:0] i_next;
    logic signed [SAMPLE_W-1:0] q_next;

    // -(-2^23) does not fit, so it is pinned to the largest positive value
    assign din_neg = (din_i == MIN_NEG) ? MAX_POS : -din_i;

    always_comb begin
        case (quad_i)
            2'b00: begin // cos +1, sin 0
                i_next = din_i;
                q_next = '0;
            end
            2'b01: begin // cos 0, sin +1
                i_next = '0;
                q_next = din_i;
            end
            2'b10: begin // cos -1, sin 0
                i_next = din_neg;
                q_next = '0;
            end
            default: begin // cos 0, sin -1
                i_next = '0;
                q_next = din_neg;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (stb_i) begin
            i_o <= i_next;
            q_o <= q_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= stb_i; // one cycle after each strobe
        end
    end

endmodule

// ==== src/lo_nco.sv ====
`timescale 1ns/1ps

module lo_nco (
    input  logic                        aclk,
    input  logic                        reset_i,
    input  logic                        step_i,
    input  logic [collect_pkg::PHASE_W-1:0] freq_i,
    input  logic                        run_i,
    output logic [1:0]                  quad_o
);

    import collect_pkg::*;

    logic [PHASE_W-1:0] phase;

    // the phase restarts from zero every time the capture is stopped
    always_ff @(posedge aclk) begin
        if (reset_i || !run_i) begin
            phase <= '0;
        end else if (step_i) begin
            phase <= phase + freq_i; // wraps modulo 2^PHASE_W
        end
    end

    // only the quadrant is needed since cos and sin are limited to +1, 0 and -1
    assign quad_o = phase[PHASE_W-1 -: 2];

endmodule

// ==== src/rate_divider.sv ====
`timescale 1ns/1ps

module rate_divider #(
    parameter int DIV = 4
) (
    input  logic aclk,
    input  logic reset_i,
    input  logic run_i,
    output logic sample_stb_o
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge aclk) begin
        if (reset_i || !run_i) begin
            cnt <= '0; // held at zero while stopped
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // strobe drops in the same cycle that run goes low
    assign sample_stb_o = run_i && (cnt == LAST);

endmodule

// ==== src/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
    input  logic                                aclk,
    input  logic                                reset_i,
    input  logic                                wr_en_i,
    input  logic                                rd_en_i,
    input  logic [collect_pkg::ADDR_W-1:0]      addr_i,
    input  logic [collect_pkg::DATA_W-1:0]      wdata_i,
    output logic [collect_pkg::DATA_W-1:0]      rdata_o,
    output logic [collect_pkg::PHASE_W-1:0]     freq_o,
    output logic [collect_pkg::COUNT_W-1:0]     thresh_o,
    output logic                                run_o,
    output logic                                irq_en_o,
    output logic                                clear_o,
    output logic                                pop_i_o,
    output logic                                pop_q_o,
    input  logic [collect_pkg::SAMPLE_W-1:0]    fifo_i_data_i,
    input  logic [collect_pkg::SAMPLE_W-1:0]    fifo_q_data_i,
    input  logic [collect_pkg::COUNT_W-1:0]     count_i_i,
    input  logic [collect_pkg::COUNT_W-1:0]     count_q_i,
    input  logic                                empty_i_i,
    input  logic                                empty_q_i,
    input  logic                                full_i_i,
    input  logic                                full_q_i,
    input  logic                                ovf_i_i,
    input  logic                                ovf_q_i
);

    import collect_pkg::*;

    localparam int EXT_W = DATA_W - SAMPLE_W;

    status_word_u      status;
    logic              rd_act;
    logic [DATA_W-1:0] rd_word;

    // a write wins when both strobes arrive together
    assign rd_act  = rd_en_i && !wr_en_i;
    assign pop_i_o = rd_act && (addr_i == REG_FIFO_I);
    assign pop_q_o = rd_act && (addr_i == REG_FIFO_Q);

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            freq_o   <= '0;
            thresh_o <= '0;
            run_o    <= 1'b0;
            irq_en_o <= 1'b0;
            clear_o  <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            if (wr_en_i) begin
                case (addr_i)
                    REG_FREQ:   freq_o   <= wdata_i[PHASE_W-1:0];
                    REG_THRESH: thresh_o <= wdata_i[COUNT_W-1:0];
                    REG_CTRL: begin
                        run_o    <= wdata_i[0];
                        irq_en_o <= wdata_i[1];
                        clear_o  <= run_o && !wdata_i[0]; // stopping flushes the FIFOs
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status.fields.reserved   = '0;
        status.fields.overflow_q = ovf_q_i;
        status.fields.overflow_i = ovf_i_i;
        status.fields.full_q     = full_q_i;
        status.fields.full_i     = full_i_i;
        status.fields.empty_q    = empty_q_i;
        status.fields.empty_i    = empty_i_i;
        status.fields.count_q    = count_q_i;
        status.fields.count_i    = count_i_i;
    end

    always_comb begin
        case (addr_i)
            REG_FREQ:   rd_word = DATA_W'(freq_o);
            REG_THRESH: rd_word = DATA_W'(thresh_o);
            REG_CTRL:   rd_word = DATA_W'({irq_en_o, run_o});
            REG_STATUS: rd_word = status.raw;
            REG_FIFO_I: rd_word = empty_i_i ? '0 :
                                  {{EXT_W{fifo_i_data_i[SAMPLE_W-1]}}, fifo_i_data_i};
            REG_FIFO_Q: rd_word = empty_q_i ? '0 :
                                  {{EXT_W{fifo_q_data_i[SAMPLE_W-1]}}, fifo_q_data_i};
            default:    rd_word = '0;
        endcase
    end

    // read data lands one cycle after the strobe and stays until the next read
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            rdata_o <= '0;
        end else if (rd_act) begin
            rdata_o <= rd_word;
        end
    end

endmodule

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                                aclk,
    input  logic                                reset_i,
    input  logic                                push_i,
    input  logic                                pop_i,
    input  logic                                clear_i,
    input  logic [collect_pkg::SAMPLE_W-1:0]    wdata_i,
    input  logic [collect_pkg::COUNT_W-1:0]     thresh_i,
    input  logic                                irq_en_i,
    output logic [collect_pkg::SAMPLE_W-1:0]    rdata_o,
    output logic [collect_pkg::COUNT_W-1:0]     count_o,
    output logic                                empty_o,
    output logic                                full_o,
    output logic                                overflow_o,
    output logic                                irq_o
);

    import collect_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [SAMPLE_W-1:0]   mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [COUNT_W-1:0]    count;
    logic                  overflow;
    logic                  push_ok;
    logic                  pop_ok;

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o; // popping an empty buffer is ignored

    always_ff @(posedge aclk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i || clear_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // pointers wrap with the power-of-two depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
            if (push_i && full_o) begin
                overflow <= 1'b1; // sticky until the next clear
            end
        end
    end

    assign rdata_o    = mem[rd_ptr];
    assign count_o    = count;
    assign empty_o    = (count == '0);
    assign full_o     = (count == COUNT_W'(DEPTH));
    assign overflow_o = overflow;

    // a zero threshold keeps the interrupt quiet
    assign irq_o = irq_en_i && (thresh_i != '0) && (count >= thresh_i);

endmodule
